// ==== Bender.yml ====
package:
  name: sprite_overlay

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sprite_video_pkg.sv
      - verilog/sprite_bus_pkg.sv
      - verilog/sprite_reg_decode.sv
      - verilog/sprite_engine.sv
      - verilog/sprite_compositor.sv
      - verilog/sprite_overlay_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/sprite_overlay_tb.sv

// ==== sim/sprite_overlay_tb.sv ====
/* Sprite overlay testbench */

`timescale 1ns/1ps
`default_nettype none

`include "sprite_defs.svh"

module sprite_overlay_tb
	import sprite_bus_pkg::*, sprite_video_pkg::*;
();

	localparam int PIXELS      = `SPRITE_WIDTH * `SPRITE_HEIGHT;
	localparam int BURST       = 32;
	localparam int WRITE_COUNT = 2 * PIXELS + 3 + 2 + 3 + 3 + BURST + 4;
	localparam int BEAT_COUNT  = 64 + 6400 + 324 + 6400 + 1024 + 64;
	localparam int WATCHDOG_NS = (WRITE_COUNT + BEAT_COUNT) * 80 + 50000;

	logic        clock;
	logic        arst_n;
	logic        bus_valid;
	bus_write_t  bus_wr;
	logic        bus_ready;
	logic        beat_valid;
	video_beat_t beat;
	logic        out_valid;
	overlay_t    out_pixel;

	logic [31:0] lfsr = 32'h20f92424;
	int          cycle = 0;
	int          show_through;   // Sprite 1 seen through a see-through sprite 0 pixel.
	int          front_hits;     // Beats where both sprites are opaque.
	string       test_name;

	pixel_t      model_mem [0:1][0:PIXELS-1];
	sprite_cfg_t model_cfg [0:1];
	overlay_t    exp_q [$];
	int          stamp_q [$];

	sprite_overlay_top UUT (
		.i_clock         (clock),
		.i_arst_n        (arst_n),
		.i_bus_valid     (bus_valid),
		.i_bus_write     (bus_wr),
		.o_bus_ready     (bus_ready),
		.i_beat_valid    (beat_valid),
		.i_beat          (beat),
		.o_overlay_valid (out_valid),
		.o_overlay       (out_pixel)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Rising edge count used by the latency and burst checks.
	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Failure path, checks and random data
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			stop_run($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);   // Galois step.
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic void model_write(input bus_write_t w);
		logic [3:0] region;
		region = w.addr[17:14];
		if (region == `REGION_REGS) begin
			case (w.addr[4:0])
				5'h00: model_cfg[0].pos_x = w.data[`COORD_W-1:0];
				5'h04: model_cfg[0].pos_y = w.data[`COORD_W-1:0];
				5'h08: model_cfg[0].visible = |w.data;
				5'h10: model_cfg[1].pos_x = w.data[`COORD_W-1:0];
				5'h14: model_cfg[1].pos_y = w.data[`COORD_W-1:0];
				5'h18: model_cfg[1].visible = |w.data;
				default: ;   // No register here.
			endcase
		end else if (region == `REGION_SPRITE0 || region == `REGION_SPRITE1) begin
			model_mem[(region == `REGION_SPRITE0) ? 0 : 1][w.addr[13:2]] = w.data[`PIXEL_W-1:0];
		end
	endfunction

	function automatic logic covers(input int s, input video_beat_t b);
		int dx;
		int dy;
		dx = int'(b.x) - int'(model_cfg[s].pos_x);
		dy = int'(b.y) - int'(model_cfg[s].pos_y);
		return model_cfg[s].visible && !b.blank && dx >= 0 && dx < `SPRITE_WIDTH
			&& dy >= 0 && dy < `SPRITE_HEIGHT;
	endfunction

	function automatic overlay_t sprite_pixel(input int s, input video_beat_t b);
		overlay_t r;
		pixel_t   p;
		int       index;
		r = '0;
		index = (int'(b.y) - int'(model_cfg[s].pos_y)) * `SPRITE_WIDTH
			+ int'(b.x) - int'(model_cfg[s].pos_x);
		if (covers(s, b)) begin
			p = model_mem[s][index];
			if (p != `SPRITE_TRANSPARENT) begin
				r.data = p;
				r.mask = 1'b1;
			end
		end
		return r;
	endfunction

	function automatic bus_addr_t pixel_addr(input int s, input int index);
		return {(s == 0) ? `REGION_SPRITE0 : `REGION_SPRITE1, pix_index_t'(index), 2'b00};
	endfunction

	// Compares each output with the beat queued three cycles before it.
	always @(negedge clock) begin : receive
		overlay_t expected;
		int       stamp;
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				stop_run("An overlay output appeared without a matching beat.");
			end else begin
				expected = exp_q.pop_front();
				stamp    = stamp_q.pop_front();
				check(test_name, 32'(expected), 32'(out_pixel));
				check({test_name, " latency"}, 3, cycle - stamp);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drivers that start and end on a falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
		int waited;
		waited    = 0;
		bus_valid = 1'b1;   // Valid stays high until the caller drops it.
		bus_wr    = {addr, data};
		while (bus_ready !== 1'b1) begin
			if (waited == 8) begin
				stop_run("The bus ready signal did not rise within 8 cycles.");
			end else begin
				@(negedge clock);
				waited++;
			end
		end
		@(negedge clock);   // Handshake on the rising edge just passed.
		model_write(bus_wr);
	endtask

	task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
		bus_write(addr, data);
		bus_valid = 1'b0;
	endtask

	task automatic fill_sprite(input int s);
		pixel_t p;
		for (int i = 0; i < PIXELS; i++) begin
			p = rand_bits(8);
			if (rand_bits(2) == 2'b11) begin
				p = `SPRITE_TRANSPARENT;   // Roughly a quarter see-through.
			end
			bus_write(pixel_addr(s, i), 32'(p));
		end
		bus_valid = 1'b0;
	endtask

	task automatic wait_outputs();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			if (n == 10) begin
				stop_run("Overlay outputs went missing and the pipeline did not drain.");
			end else begin
				@(negedge clock);
				n++;
			end
		end
	endtask

	task automatic send_region(input int x0, input int y0, input int w, input int h,
		input logic blanked);
		video_beat_t b;
		overlay_t    r0;
		overlay_t    r1;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				b.x     = coord_t'(x0 + x);
				b.y     = coord_t'(y0 + y);
				b.blank = blanked;
				r0 = sprite_pixel(0, b);
				r1 = sprite_pixel(1, b);
				if (covers(0, b) && !r0.mask && r1.mask) begin
					show_through++;
				end
				if (r0.mask && r1.mask) begin
					front_hits++;
				end
				beat_valid = 1'b1;
				beat       = b;
				exp_q.push_back(r0.mask ? r0 : r1);   // Sprite 0 in front.
				stamp_q.push_back(cycle);
				@(negedge clock);
			end
		end
		beat_valid = 1'b0;
		wait_outputs();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic verify_reset();
		test_name = "reset";
		@(negedge clock);
		check(test_name, 0, bus_ready);
		check(test_name, 0, out_valid);
		@(negedge clock);   // Two rising edges have passed in reset.
		arst_n = 1'b1;
		check(test_name, 0, bus_ready);
		check(test_name, 0, out_valid);
		@(negedge clock);
		send_region(0, 0, 16, 4, 1'b0);   // No sprite is visible yet.
	endtask

	task automatic show_single_sprite();
		test_name = "single sprite";
		fill_sprite(0);
		write_reg(18'h00000, 100);
		write_reg(18'h00004, 50);
		write_reg(18'h00008, 1);
		send_region(90, 40, 80, 80, 1'b0);
	endtask

	task automatic hide_transparent_and_blank();
		test_name = "transparency";
		write_reg(pixel_addr(0, 0), 32'h0000_00ff);
		write_reg(pixel_addr(0, 5 * `SPRITE_WIDTH + 7), 32'h1234_56ff);
		send_region(100, 50, 2, 1, 1'b0);
		send_region(107, 55, 2, 1, 1'b0);
		test_name = "blanking";
		send_region(100, 50, 64, 4, 1'b1);
		test_name = "outside";
		send_region(100, 49, 64, 1, 1'b0);
	endtask

	task automatic resolve_priority();
		test_name = "priority";
		fill_sprite(1);
		write_reg(18'h00010, 130);
		write_reg(18'h00014, 80);
		write_reg(18'h00018, 1);
		show_through = 0;
		front_hits   = 0;
		send_region(120, 70, 80, 80, 1'b0);
		check("priority show-through seen", 1, show_through > 0);
		check("priority overlap seen", 1, front_hits > 0);
	endtask

	task automatic toggle_and_move();
		test_name = "visibility";
		write_reg(18'h00008, 0);
		send_region(130, 80, 16, 16, 1'b0);
		write_reg(18'h00008, 32'h0100_0000);   // Any set bit makes it visible.
		send_region(130, 80, 16, 16, 1'b0);
		test_name = "move";
		write_reg(18'h00000, 300);
		send_region(100, 50, 16, 16, 1'b0);
		send_region(300, 50, 16, 16, 1'b0);
	endtask

	task automatic exercise_bus();
		int start;
		test_name = "bus burst";
		start     = cycle;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 8; c++) begin
				bus_write(pixel_addr(1, r * `SPRITE_WIDTH + c), rand_bits(32));
			end
		end
		check("bus burst cycles", 2 * BURST - 1, cycle - start);
		bus_valid = 1'b0;
		send_region(130, 80, 8, 4, 1'b0);
		test_name = "unmapped";
		bus_write(18'h0c004, rand_bits(32));   // Region 3.
		bus_write(18'h3c008, rand_bits(32));   // Region 15.
		bus_write(18'h0000c, 32'h0);           // Zero would clear a visible flag here.
		bus_write(18'h0001c, 32'h0);
		bus_valid = 1'b0;
		send_region(130, 80, 8, 4, 1'b0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		stop_run("The run timed out before all tests finished.");
	end

	initial begin
		arst_n     = 1'b0;
		bus_valid  = 1'b0;
		bus_wr     = '0;
		beat_valid = 1'b0;
		beat       = '0;
		model_cfg[0] = '0;
		model_cfg[1] = '0;
		verify_reset();
		show_single_sprite();
		hide_transparent_and_blank();
		resolve_priority();
		toggle_and_move();
		exercise_bus();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sprite_overlay.f ====
+incdir+verilog
verilog/sprite_video_pkg.sv
verilog/sprite_bus_pkg.sv
verilog/sprite_reg_decode.sv
verilog/sprite_engine.sv
verilog/sprite_compositor.sv
verilog/sprite_overlay_top.sv
sim/sprite_overlay_tb.sv

// ==== verilog/sprite_bus_pkg.sv ====
/* Write bus types */

`default_nettype none

`include "sprite_defs.svh"

package sprite_bus_pkg;

	import sprite_video_pkg::*;

	typedef logic [17:0] bus_addr_t;   // Byte address, region in bits 17..14.
	typedef logic [31:0] bus_data_t;   // Write data word.

	// One write on the CPU bus.
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data;
	} bus_write_t;

	typedef logic [`SPRITE_ADDR_W-1:0] pix_index_t;   // Pixel memory index.

	// One write into a sprite pixel memory.
	typedef struct packed {
		pix_index_t index;
		pixel_t     data;
	} pix_write_t;

endpackage

`default_nettype wire

// ==== verilog/sprite_compositor.sv ====
/* Sprite priority mixer */

`timescale 1ns/1ps
`default_nettype none

module sprite_compositor
	import sprite_video_pkg::*;
(
	input  wire      i_clock,
	input  wire      i_arst_n,

	input  wire      i_valid0,
	input  overlay_t i_pixel0,

	input  wire      i_valid1,
	input  overlay_t i_pixel1,

	output logic     o_overlay_valid,
	output overlay_t o_overlay
);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_overlay_valid <= 1'b0;
			o_overlay       <= '0;
		end else begin
			o_overlay_valid <= i_valid0;   // Both engines run in lockstep.
			if (i_pixel0.mask) begin
				o_overlay <= i_pixel0;   // Sprite 0 sits in front.
			end else if (i_pixel1.mask) begin
				o_overlay <= i_pixel1;
			end else begin
				o_overlay <= '0;
			end
		end
	end

	// Engines share the beat stream, so their pipelines must never drift apart.
	a_valid_lockstep: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_valid0 == i_valid1);

endmodule

`default_nettype wire

// ==== verilog/sprite_defs.svh ====
/* Sprite layer constants */

`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SPRITE_WIDTH       64    // Pixels per sprite row and a power of two.
`define SPRITE_HEIGHT      64    // Rows per sprite.
`define SPRITE_ADDR_W      12    // Log2 of width times height.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define COORD_W            11    // Screen coordinate bits.
`define PIXEL_W            8     // Bits per pixel.
`define SPRITE_TRANSPARENT 8'hff // Colour key that lets lower layers through.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus regions selected by address bits 17..14
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define REGION_REGS        4'h0  // Position and visibility registers.
`define REGION_SPRITE0     4'h1  // Pixel memory of sprite 0.
`define REGION_SPRITE1     4'h2  // Pixel memory of sprite 1.

`endif

// ==== verilog/sprite_engine.sv ====
/* Sprite hit test and pixel fetch */

`timescale 1ns/1ps
`default_nettype none

`include "sprite_defs.svh"

module sprite_engine
	import sprite_bus_pkg::*, sprite_video_pkg::*;
(
	input  wire         i_clock,
	input  wire         i_arst_n,

	input  sprite_cfg_t i_cfg,

	input  pix_write_t  i_pix_write,
	input  wire         i_pix_write_valid,

	input  wire         i_beat_valid,
	input  video_beat_t i_beat,

	output logic        o_pixel_valid,
	output overlay_t    o_pixel
);

	localparam int DEPTH = `SPRITE_WIDTH * `SPRITE_HEIGHT;

	pixel_t     mem [0:DEPTH-1];   // Sprite image in row major order.

	coord_t     dx;
	coord_t     dy;
	logic       hit;
	pix_index_t hit_index;

	logic       s1_valid;
	logic       s1_inside;
	pix_index_t s1_index;

	logic       s2_valid;
	logic       s2_inside;
	pixel_t     s2_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1 hit test
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		dx  = i_beat.x - i_cfg.pos_x;   // Only meaningful when x >= pos_x.
		dy  = i_beat.y - i_cfg.pos_y;
		hit = i_beat_valid && i_cfg.visible && !i_beat.blank
			&& (i_beat.x >= i_cfg.pos_x) && (dx < coord_t'(`SPRITE_WIDTH))
			&& (i_beat.y >= i_cfg.pos_y) && (dy < coord_t'(`SPRITE_HEIGHT));
		hit_index = pix_index_t'(int'(dy) * `SPRITE_WIDTH + int'(dx));
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			s1_valid  <= 1'b0;
			s1_inside <= 1'b0;
			s2_valid  <= 1'b0;
			s2_inside <= 1'b0;
		end else begin
			s1_valid  <= i_beat_valid;
			s1_inside <= hit;
			s2_valid  <= s1_valid;
			s2_inside <= s1_inside;
		end
	end

	always_ff @(posedge i_clock) begin
		s1_index <= hit_index;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2 pixel memory read
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A read in the same cycle as a write to its index sees the old pixel.
	always_ff @(posedge i_clock) begin
		if (i_pix_write_valid) begin
			mem[i_pix_write.index] <= i_pix_write.data;
		end
		s2_data <= mem[s1_index];
	end

	always_comb begin
		o_pixel_valid = s2_valid;
		o_pixel.mask  = s2_inside && (s2_data != `SPRITE_TRANSPARENT);
		o_pixel.data  = o_pixel.mask ? s2_data : '0;   // Keep the bus quiet when hidden.
	end

	a_mask_valid: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_pixel.mask |-> o_pixel_valid);

endmodule

`default_nettype wire

// ==== verilog/sprite_overlay_top.sv ====
/* Two sprite overlay */

`timescale 1ns/1ps
`default_nettype none

module sprite_overlay_top
	import sprite_bus_pkg::*, sprite_video_pkg::*;
(
	input  wire         i_clock,
	input  wire         i_arst_n,

	input  wire         i_bus_valid,
	input  bus_write_t  i_bus_write,
	output logic        o_bus_ready,

	input  wire         i_beat_valid,
	input  video_beat_t i_beat,

	output logic        o_overlay_valid,
	output overlay_t    o_overlay
);

	sprite_cfg_t cfg0;
	sprite_cfg_t cfg1;
	pix_write_t  pix_write;
	logic        pix_write_valid0;
	logic        pix_write_valid1;

	logic        valid0;
	logic        valid1;
	overlay_t    pixel0;
	overlay_t    pixel1;

	sprite_reg_decode decode (
		.i_clock            (i_clock),
		.i_arst_n           (i_arst_n),
		.i_bus_valid        (i_bus_valid),
		.i_bus_write        (i_bus_write),
		.o_bus_ready        (o_bus_ready),
		.o_cfg0             (cfg0),
		.o_cfg1             (cfg1),
		.o_pix_write        (pix_write),
		.o_pix_write_valid0 (pix_write_valid0),
		.o_pix_write_valid1 (pix_write_valid1)
	);

	sprite_engine sprite0 (
		.i_clock           (i_clock),
		.i_arst_n          (i_arst_n),
		.i_cfg             (cfg0),
		.i_pix_write       (pix_write),
		.i_pix_write_valid (pix_write_valid0),
		.i_beat_valid      (i_beat_valid),
		.i_beat            (i_beat),
		.o_pixel_valid     (valid0),
		.o_pixel           (pixel0)
	);

	sprite_engine sprite1 (
		.i_clock           (i_clock),
		.i_arst_n          (i_arst_n),
		.i_cfg             (cfg1),
		.i_pix_write       (pix_write),
		.i_pix_write_valid (pix_write_valid1),
		.i_beat_valid      (i_beat_valid),
		.i_beat            (i_beat),
		.o_pixel_valid     (valid1),
		.o_pixel           (pixel1)
	);

	sprite_compositor compositor (
		.i_clock         (i_clock),
		.i_arst_n        (i_arst_n),
		.i_valid0        (valid0),
		.i_pixel0        (pixel0),
		.i_valid1        (valid1),
		.i_pixel1        (pixel1),
		.o_overlay_valid (o_overlay_valid),
		.o_overlay       (o_overlay)
	);

endmodule

`default_nettype wire

// ==== verilog/sprite_reg_decode.sv ====
/* Sprite register decoder */

`timescale 1ns/1ps
`default_nettype none

`include "sprite_defs.svh"

module sprite_reg_decode
	import sprite_bus_pkg::*, sprite_video_pkg::*;
(
	input  wire         i_clock,
	input  wire         i_arst_n,

	input  wire         i_bus_valid,
	input  bus_write_t  i_bus_write,
	output logic        o_bus_ready,

	output sprite_cfg_t o_cfg0,
	output sprite_cfg_t o_cfg1,

	output pix_write_t  o_pix_write,
	output logic        o_pix_write_valid0,
	output logic        o_pix_write_valid1
);

	logic       handshake;
	logic [3:0] region;
	logic [4:0] offset;

	always_comb begin
		handshake = i_bus_valid && o_bus_ready;   // Write accepted this edge.
		region    = i_bus_write.addr[17:14];
		offset    = i_bus_write.addr[4:0];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake and register file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_bus_ready        <= 1'b0;
			o_cfg0             <= '0;
			o_cfg1             <= '0;
			o_pix_write_valid0 <= 1'b0;
			o_pix_write_valid1 <= 1'b0;
		end else begin
			o_bus_ready        <= !handshake;   // One idle cycle after each write.
			o_pix_write_valid0 <= handshake && (region == `REGION_SPRITE0);
			o_pix_write_valid1 <= handshake && (region == `REGION_SPRITE1);
			if (handshake && region == `REGION_REGS) begin
				case (offset)
					5'h00: o_cfg0.pos_x   <= i_bus_write.data[`COORD_W-1:0];
					5'h04: o_cfg0.pos_y   <= i_bus_write.data[`COORD_W-1:0];
					5'h08: o_cfg0.visible <= |i_bus_write.data;
					5'h10: o_cfg1.pos_x   <= i_bus_write.data[`COORD_W-1:0];
					5'h14: o_cfg1.pos_y   <= i_bus_write.data[`COORD_W-1:0];
					5'h18: o_cfg1.visible <= |i_bus_write.data;
					default: ;   // Unmapped offsets are swallowed.
				endcase
			end
		end
	end

	// Pixel payload is shared by both memories; the valids pick the target.
	always_ff @(posedge i_clock) begin
		if (handshake) begin
			o_pix_write.index <= i_bus_write.addr[`SPRITE_ADDR_W+1:2];
			o_pix_write.data  <= i_bus_write.data[`PIXEL_W-1:0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_one_pix_write: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		$onehot0({o_pix_write_valid0, o_pix_write_valid1}));

	a_ready_in_reset: assert property (@(posedge i_clock)
		!i_arst_n |-> !o_bus_ready);

endmodule

`default_nettype wire

// ==== verilog/sprite_video_pkg.sv ====
/* Video path types */

`default_nettype none

`include "sprite_defs.svh"

package sprite_video_pkg;

	typedef logic [`COORD_W-1:0] coord_t;   // Screen coordinate.
	typedef logic [`PIXEL_W-1:0] pixel_t;   // One palette index.

	// One screen position from the timing generator.
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   blank;   // Set outside the active picture.
	} video_beat_t;

	// Registers of one sprite.
	typedef struct packed {
		coord_t pos_x;   // Left edge on screen.
		coord_t pos_y;   // Top edge on screen.
		logic   visible;
	} sprite_cfg_t;

	// One overlay output pixel.
	typedef struct packed {
		pixel_t data;    // Zero whenever mask is clear.
		logic   mask;    // Set where a sprite covers the position.
	} overlay_t;

endpackage

`default_nettype wire
